//--- soc_defines.svh
// SoC glue parameters: address map, memory depths, timer and debug window constants
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

`define SOC_ADDR_W        32
`define SOC_DATA_W        32

// Address map, base and length per target
`define ROM_BASE          32'h0000_1000
`define ROM_LEN           32'h0000_0100
`define ROM_WORDS         64
`define RAM_BASE          32'h8000_0000
`define RAM_LEN           32'h0000_0400
`define RAM_WORDS         256
`define CLINT_BASE        32'h0200_0000
`define CLINT_LEN         32'h0000_0010

// CLINT register offsets and reset values
`define CLINT_MTIMECMP_OFF 4'h0
`define CLINT_MTIME_OFF    4'h8
`define MTIMECMP_RST      32'hFFFF_FFFF
`define MTIME_RST         32'h0000_0000

`define ROM_SIG           16'hB007
`define DBG_DELAY_CYCLES  20

`define REGION_NONE       2'd0
`define REGION_ROM        2'd1
`define REGION_RAM        2'd2
`define REGION_CLINT      2'd3

`endif

//--- soc_pkg.sv
// SoC bus package: width types and the request and response structs
`include "soc_defines.svh"

package soc_pkg;

  // ----------------------------------------------------------------------
  // Width types
  // ----------------------------------------------------------------------
  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;

  // Target index as produced by the address decoder
  typedef logic [1:0] region_t;

  // ----------------------------------------------------------------------
  // Bus structs
  // ----------------------------------------------------------------------
  // Single-cycle request, no back-pressure
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Response, two cycles behind its request
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

endpackage

//--- bus_decoder.sv
// Bus decoder: registers each request and maps its address to a target region
`timescale 1ns/1ps
`include "soc_defines.svh"

module bus_decoder (
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  soc_pkg::bus_req_t  req_i,
  output soc_pkg::bus_req_t  stage1_req_o,
  output soc_pkg::region_t   stage1_region_o
);

  logic              hit_rom;
  logic              hit_ram;
  logic              hit_clint;
  soc_pkg::region_t  region_d;

  logic              valid_q;
  logic              we_q;
  soc_pkg::addr_t    addr_q;
  soc_pkg::data_t    wdata_q;
  soc_pkg::region_t  region_q;

  // Address map rules, start inclusive and end exclusive
  assign hit_rom   = (req_i.addr >= `ROM_BASE) && (req_i.addr < `ROM_BASE + `ROM_LEN);
  assign hit_ram   = (req_i.addr >= `RAM_BASE) && (req_i.addr < `RAM_BASE + `RAM_LEN);
  assign hit_clint = (req_i.addr >= `CLINT_BASE) && (req_i.addr < `CLINT_BASE + `CLINT_LEN);

  // No default port, so a miss maps to the error region
  always_comb begin
    region_d = `REGION_NONE;
    if (hit_rom)   region_d = `REGION_ROM;
    if (hit_ram)   region_d = `REGION_RAM;
    if (hit_clint) region_d = `REGION_CLINT;
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q  <= 1'b0;
      region_q <= `REGION_NONE;
    end else begin
      valid_q  <= req_i.valid;
      region_q <= region_d;
    end
  end

  always_ff @(posedge clk_i) begin
    we_q    <= req_i.we;
    addr_q  <= req_i.addr;
    wdata_q <= req_i.wdata;
  end

  assign stage1_req_o    = '{valid: valid_q, we: we_q, addr: addr_q, wdata: wdata_q};
  assign stage1_region_o = region_q;

endmodule

//--- boot_rom.sv
// Boot ROM: fixed signature-tagged words behind a registered read port
`timescale 1ns/1ps
`include "soc_defines.svh"

module boot_rom (
  input  logic               clk_i,
  input  soc_pkg::bus_req_t  req_i,
  input  logic               sel_i,
  output soc_pkg::data_t     rdata_o
);

  localparam int unsigned IdxW = $clog2(`ROM_WORDS);

  soc_pkg::data_t   rom_mem [`ROM_WORDS];
  logic [IdxW-1:0]  rd_idx;
  logic             rd_en;

  // Word i carries the signature on top and its own index below
  for (genvar i = 0; i < `ROM_WORDS; i++) begin : g_rom_word
    assign rom_mem[i] = {`ROM_SIG, 16'(i)};
  end

  assign rd_idx = req_i.addr[2 +: IdxW];

  // Writes are dropped here, the error comes from the response stage
  assign rd_en = sel_i & req_i.valid & ~req_i.we;

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= rom_mem[rd_idx];
    end
  end

endmodule

//--- scratch_ram.sv
// Scratchpad RAM: word-addressed stand-in for L2 with registered access
`timescale 1ns/1ps
`include "soc_defines.svh"

module scratch_ram (
  input  logic               clk_i,
  input  soc_pkg::bus_req_t  req_i,
  input  logic               sel_i,
  output soc_pkg::data_t     rdata_o
);

  localparam int unsigned IdxW = $clog2(`RAM_WORDS);

  soc_pkg::data_t   ram_mem [`RAM_WORDS];
  logic [IdxW-1:0]  idx;
  logic             access;

  assign idx    = req_i.addr[2 +: IdxW];
  assign access = sel_i & req_i.valid;

  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      ram_mem[idx] <= req_i.wdata;
    end
    if (access && !req_i.we) begin
      rdata_o <= ram_mem[idx];
    end
  end

endmodule

//--- clint_timer.sv
// Core-local timer: divided RTC counter, compare register and timer interrupt
`timescale 1ns/1ps
`include "soc_defines.svh"

module clint_timer (
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  soc_pkg::bus_req_t  req_i,
  input  logic               sel_i,
  input  logic               rtc_i,
  output soc_pkg::data_t     rdata_o,
  output logic               timer_irq_o
);

  // ----------------------------------------------------------------------
  // RTC synchroniser and divide by two
  // ----------------------------------------------------------------------
  // Stages 0 and 1 synchronise, stage 2 keeps the previous level
  logic [2:0]      rtc_q;
  logic            rtc_rise;
  logic            div_q;
  logic            tick;

  soc_pkg::data_t  mtime_q;
  soc_pkg::data_t  mtimecmp_q;
  logic            wr_en;
  logic            rd_en;

  assign rtc_rise = rtc_q[1] & ~rtc_q[2];
  assign tick     = rtc_rise & div_q;

  assign wr_en = sel_i & req_i.valid & req_i.we;
  assign rd_en = sel_i & req_i.valid & ~req_i.we;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q      <= '0;
      div_q      <= 1'b0;
      mtime_q    <= `MTIME_RST;
      mtimecmp_q <= `MTIMECMP_RST;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      if (rtc_rise) div_q <= ~div_q;
      // Bus write to mtime wins over the tick
      if (wr_en && req_i.addr[3:0] == `CLINT_MTIME_OFF) begin
        mtime_q <= req_i.wdata;
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && req_i.addr[3:0] == `CLINT_MTIMECMP_OFF) begin
        mtimecmp_q <= req_i.wdata;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Register read port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      unique case (req_i.addr[3:0])
        `CLINT_MTIMECMP_OFF: rdata_o <= mtimecmp_q;
        `CLINT_MTIME_OFF:    rdata_o <= mtime_q;
        default:             rdata_o <= '0;
      endcase
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

//--- resp_mux.sv
// Response stage: lines up region with target data and builds the response
`timescale 1ns/1ps
`include "soc_defines.svh"

module resp_mux (
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  soc_pkg::bus_req_t  stage1_req_i,
  input  soc_pkg::region_t   stage1_region_i,
  input  soc_pkg::data_t     rom_rdata_i,
  input  soc_pkg::data_t     ram_rdata_i,
  input  soc_pkg::data_t     clint_rdata_i,
  output soc_pkg::bus_rsp_t  rsp_o
);

  logic              valid_q;
  logic              we_q;
  soc_pkg::region_t  region_q;
  logic              err;
  soc_pkg::data_t    rd_word;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= `REGION_NONE;
    end else begin
      valid_q  <= stage1_req_i.valid;
      we_q     <= stage1_req_i.we;
      region_q <= stage1_region_i;
    end
  end

  // Unmapped address or write into ROM
  assign err = (region_q == `REGION_NONE) || (we_q && region_q == `REGION_ROM);

  always_comb begin
    unique case (region_q)
      `REGION_ROM:   rd_word = rom_rdata_i;
      `REGION_RAM:   rd_word = ram_rdata_i;
      `REGION_CLINT: rd_word = clint_rdata_i;
      default:       rd_word = '0;
    endcase
    rsp_o.valid = valid_q;
    rsp_o.err   = valid_q & err;
    // Writes and errors return a zero word
    rsp_o.rdata = (valid_q && !err && !we_q) ? rd_word : '0;
  end

endmodule

//--- debug_req_gate.sv
// Debug request gate: holds off debug requests for a window after reset
`timescale 1ns/1ps
`include "soc_defines.svh"

module debug_req_gate (
  input  logic  clk_i,
  input  logic  ndmreset_n,
  input  logic  debug_req_i,
  output logic  debug_req_o
);

  localparam int unsigned CntW = $clog2(`DBG_DELAY_CYCLES + 1);

  // Lets the core run its boot code before it can be halted
  logic [CntW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CntW'(`DBG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q != '0) ? 1'b0 : debug_req_i;

endmodule

//--- soc_top.sv
// SoC glue top: decoder, boot ROM, scratchpad, CLINT, response stage, debug gate
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_top (
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  soc_pkg::bus_req_t  req_i,
  output soc_pkg::bus_rsp_t  rsp_o,
  input  logic               rtc_i,
  output logic               timer_irq_o,
  input  logic               debug_req_i,
  output logic               debug_req_o
);

  soc_pkg::bus_req_t  stage1_req;
  soc_pkg::region_t   stage1_region;
  logic               rom_sel;
  logic               ram_sel;
  logic               clint_sel;
  soc_pkg::data_t     rom_rdata;
  soc_pkg::data_t     ram_rdata;
  soc_pkg::data_t     clint_rdata;

  // ----------------------------------------------------------------------
  // Request side
  // ----------------------------------------------------------------------
  bus_decoder i_decoder (
    .clk_i           ( clk_i         ),
    .ndmreset_n      ( ndmreset_n    ),
    .req_i           ( req_i         ),
    .stage1_req_o    ( stage1_req    ),
    .stage1_region_o ( stage1_region )
  );

  assign rom_sel   = (stage1_region == `REGION_ROM);
  assign ram_sel   = (stage1_region == `REGION_RAM);
  assign clint_sel = (stage1_region == `REGION_CLINT);

  // ----------------------------------------------------------------------
  // Targets
  // ----------------------------------------------------------------------
  boot_rom i_rom (
    .clk_i   ( clk_i      ),
    .req_i   ( stage1_req ),
    .sel_i   ( rom_sel    ),
    .rdata_o ( rom_rdata  )
  );

  scratch_ram i_ram (
    .clk_i   ( clk_i      ),
    .req_i   ( stage1_req ),
    .sel_i   ( ram_sel    ),
    .rdata_o ( ram_rdata  )
  );

  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( stage1_req  ),
    .sel_i       ( clint_sel   ),
    .rtc_i       ( rtc_i       ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o )
  );

  // ----------------------------------------------------------------------
  // Response side and debug window
  // ----------------------------------------------------------------------
  resp_mux i_resp_mux (
    .clk_i           ( clk_i         ),
    .ndmreset_n      ( ndmreset_n    ),
    .stage1_req_i    ( stage1_req    ),
    .stage1_region_i ( stage1_region ),
    .rom_rdata_i     ( rom_rdata     ),
    .ram_rdata_i     ( ram_rdata     ),
    .clint_rdata_i   ( clint_rdata   ),
    .rsp_o           ( rsp_o         )
  );

  debug_req_gate i_dbg_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- soc_asserts.sv
// Concurrent checks on soc_top response latency, error data and debug window
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_asserts (
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  soc_pkg::bus_req_t  req_i,
  input  soc_pkg::bus_rsp_t  rsp_i,
  input  logic               dbg_blocked_i,
  input  logic               debug_req_gated_i
);

  int unsigned fail_cnt = 0;

  logic        in_rom;
  logic        in_ram;
  logic        in_clint;
  logic        bad_req;
  int unsigned win_cnt_q;

  // Offset from each base wraps below it, so one compare covers both ends
  assign in_rom   = (req_i.addr - `ROM_BASE) < `ROM_LEN;
  assign in_ram   = (req_i.addr - `RAM_BASE) < `RAM_LEN;
  assign in_clint = (req_i.addr - `CLINT_BASE) < `CLINT_LEN;
  assign bad_req  = !(in_rom || in_ram || in_clint) || (req_i.we && in_rom);

  // Cycles since reset release, saturating at the window length
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      win_cnt_q <= 0;
    end else if (win_cnt_q < `DBG_DELAY_CYCLES) begin
      win_cnt_q <= win_cnt_q + 1;
    end
  end

  // Fixed two-cycle response latency
  rsp_latency: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i.valid |-> ##2 rsp_i.valid)
    else begin
      fail_cnt++;
      $error("No response two cycles after a request");
    end

  err_zero_data: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (req_i.valid && bad_req) |-> ##2 (rsp_i.err && rsp_i.rdata == '0))
    else begin
      fail_cnt++;
      $error("Unmapped or ROM write request without a zero-data error response");
    end

  dbg_window: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (win_cnt_q < `DBG_DELAY_CYCLES) |-> (dbg_blocked_i && !debug_req_gated_i))
    else begin
      fail_cnt++;
      $error("Debug request passed inside the window after reset");
    end

endmodule

bind soc_top soc_asserts i_asserts (
  .clk_i             ( clk_i                    ),
  .ndmreset_n        ( ndmreset_n               ),
  .req_i             ( req_i                    ),
  .rsp_i             ( rsp_o                    ),
  .dbg_blocked_i     ( i_dbg_gate.cnt_q != '0   ),
  .debug_req_gated_i ( debug_req_o              )
);

//--- tb_soc_top.sv
// Testbench for soc_top: table-driven bus traffic, timer interrupt and debug window checks
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc_top;

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_ROWS    = 22;
  localparam int RTC_PULSES  = 6;
  localparam int RTC_HALF    = 4;
  localparam int WDOG_CYCLES = NUM_ROWS + RTC_PULSES * 2 * RTC_HALF + `DBG_DELAY_CYCLES + 200;

  logic               clk_i;
  logic               ndmreset_n;
  soc_pkg::bus_req_t  req_i;
  soc_pkg::bus_rsp_t  rsp_o;
  logic               rtc_i;
  logic               timer_irq_o;
  logic               debug_req_i;
  logic               debug_req_o;

  // Stimulus table, one request per row
  logic               tbl_we    [NUM_ROWS];
  soc_pkg::addr_t     tbl_addr  [NUM_ROWS];
  soc_pkg::data_t     tbl_wdata [NUM_ROWS];
  logic               tbl_err   [NUM_ROWS];
  soc_pkg::data_t     tbl_rdata [NUM_ROWS];
  int                 n_rows;

  // Outstanding responses in issue order
  logic               exp_err_q  [$];
  soc_pkg::data_t     exp_data_q [$];
  logic               exp_min_q  [$];
  int                 exp_cyc_q  [$];

  int                 cyc = 0;
  int                 err_cnt;
  logic [31:0]        rnd_state;

  soc_top uut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .rsp_o       ( rsp_o       ),
    .rtc_i       ( rtc_i       ),
    .timer_irq_o ( timer_irq_o ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("The run timed out before all tests completed");
    $display("Verification failed");
    $finish;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input logic we, input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                         input logic err, input soc_pkg::data_t rdata);
    tbl_we[n_rows]    = we;
    tbl_addr[n_rows]  = addr;
    tbl_wdata[n_rows] = wdata;
    tbl_err[n_rows]   = err;
    tbl_rdata[n_rows] = rdata;
    n_rows++;
  endtask

  task automatic build_table();
    soc_pkg::data_t ram_data [4];
    int             ram_idx  [4];
    ram_idx = '{0, 17, 200, 255};
    // ROM words carry the signature above the word index
    add_row(1'b0, `ROM_BASE + 32'h00, '0, 1'b0, {`ROM_SIG, 16'd0});
    add_row(1'b0, `ROM_BASE + 32'h14, '0, 1'b0, {`ROM_SIG, 16'd5});
    add_row(1'b0, `ROM_BASE + 32'hFC, '0, 1'b0, {`ROM_SIG, 16'd63});
    add_row(1'b1, `ROM_BASE + 32'h08, 32'hDEAD_BEEF, 1'b1, '0);
    for (int i = 0; i < 4; i++) begin
      rnd_state   = next_random(rnd_state);
      ram_data[i] = rnd_state;
      add_row(1'b1, `RAM_BASE + 32'(ram_idx[i] * 4), ram_data[i], 1'b0, '0);
    end
    // Reads right behind the writes
    for (int i = 0; i < 4; i++) begin
      add_row(1'b0, `RAM_BASE + 32'(ram_idx[i] * 4), '0, 1'b0, ram_data[i]);
    end
    // Outside every rule
    add_row(1'b0, `ROM_BASE + `ROM_LEN, '0, 1'b1, '0);
    add_row(1'b0, `ROM_BASE - 32'h4, '0, 1'b1, '0);
    add_row(1'b0, 32'h0, '0, 1'b1, '0);
    add_row(1'b1, `RAM_BASE + `RAM_LEN, 32'h1234_5678, 1'b1, '0);
    add_row(1'b0, `CLINT_BASE + `CLINT_LEN, '0, 1'b1, '0);
    // CLINT setup for the timer phase, rtc_i still idle
    add_row(1'b1, `CLINT_BASE + `CLINT_MTIME_OFF, 32'd0, 1'b0, '0);
    add_row(1'b1, `CLINT_BASE + `CLINT_MTIMECMP_OFF, 32'd3, 1'b0, '0);
    add_row(1'b0, `CLINT_BASE + `CLINT_MTIMECMP_OFF, '0, 1'b0, 32'd3);
    add_row(1'b0, `CLINT_BASE + `CLINT_MTIME_OFF, '0, 1'b0, 32'd0);
    add_row(1'b0, `CLINT_BASE + 32'h4, '0, 1'b0, 32'd0);
  endtask

  task automatic send_request(input logic we, input soc_pkg::addr_t addr,
                              input soc_pkg::data_t wdata, input logic err,
                              input soc_pkg::data_t rdata, input logic min_only);
    @(posedge clk_i);
    req_i <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
    exp_err_q.push_back(err);
    exp_data_q.push_back(rdata);
    exp_min_q.push_back(min_only);
    // Counter value once this edge has passed
    exp_cyc_q.push_back(cyc + 1);
  endtask

  task automatic wait_drained();
    while (exp_err_q.size() != 0) @(negedge clk_i);
  endtask

  // ---------------------------------------------------------------------
  // Response monitor, sampled mid-cycle
  // ---------------------------------------------------------------------
  always @(negedge clk_i) begin : rsp_monitor
    logic           e_err;
    soc_pkg::data_t e_data;
    logic           e_min;
    int             e_cyc;
    if (ndmreset_n && rsp_o.valid) begin
      assert (exp_err_q.size() != 0) else begin
        err_cnt++;
        $display("A response arrived at %0t with no request outstanding", $time);
      end
      if (exp_err_q.size() != 0) begin
        e_err  = exp_err_q.pop_front();
        e_data = exp_data_q.pop_front();
        e_min  = exp_min_q.pop_front();
        e_cyc  = exp_cyc_q.pop_front();
        assert (cyc == e_cyc + 2) else begin
          err_cnt++;
          $display("[ERROR] %0t: response in cycle %0d, expected %0d", $time, cyc, e_cyc + 2);
        end
        assert (rsp_o.err == e_err) else begin
          err_cnt++;
          $display("[ERROR] %0t: err %0b, expected %0b", $time, rsp_o.err, e_err);
        end
        if (e_min) begin
          assert (rsp_o.rdata >= e_data) else begin
            err_cnt++;
            $display("[ERROR] %0t: rdata %0d below %0d", $time, rsp_o.rdata, e_data);
          end
        end else begin
          assert (rsp_o.rdata == e_data) else begin
            err_cnt++;
            $display("[ERROR] %0t: rdata %h, expected %h", $time, rsp_o.rdata, e_data);
          end
        end
      end
    end
  end

  initial begin
    ndmreset_n  = 1'b0;
    req_i       = '0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    err_cnt     = 0;
    n_rows      = 0;
    rnd_state   = 32'hc0b32038;
    build_table();

    repeat (5) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    // Debug window counted from the release edge
    for (int i = 0; i < `DBG_DELAY_CYCLES; i++) begin
      @(negedge clk_i);
      assert (debug_req_o == 1'b0) else begin
        err_cnt++;
        $display("[ERROR] %0t: debug_req_o high inside the delay window", $time);
      end
    end
    @(negedge clk_i);
    assert (debug_req_o == 1'b1) else begin
      err_cnt++;
      $display("[ERROR] %0t: debug_req_o still low after the delay window", $time);
    end
    assert (timer_irq_o == 1'b0) else begin
      err_cnt++;
      $display("[ERROR] %0t: timer_irq_o high after reset", $time);
    end

    for (int r = 0; r < n_rows; r++) begin
      send_request(tbl_we[r], tbl_addr[r], tbl_wdata[r], tbl_err[r], tbl_rdata[r], 1'b0);
    end
    @(posedge clk_i);
    req_i <= '0;
    wait_drained();

    @(negedge clk_i);
    assert (timer_irq_o == 1'b0) else begin
      err_cnt++;
      $display("[ERROR] %0t: timer_irq_o high before any RTC pulse", $time);
    end

    // RTC pulses, then time for synchroniser and divider
    for (int t = 0; t < 2 * RTC_PULSES; t++) begin
      repeat (RTC_HALF) @(posedge clk_i);
      rtc_i <= ~rtc_i;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    assert (timer_irq_o == 1'b1) else begin
      err_cnt++;
      $display("[ERROR] %0t: timer_irq_o low with mtime past mtimecmp", $time);
    end
    send_request(1'b0, `CLINT_BASE + `CLINT_MTIME_OFF, '0, 1'b0, 32'd3, 1'b1);
    @(posedge clk_i);
    req_i <= '0;
    wait_drained();
    repeat (3) @(negedge clk_i);

    $display("Check errors: %0d, assertion errors: %0d", err_cnt, uut.i_asserts.fail_cnt);
    if (err_cnt == 0 && uut.i_asserts.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
soc_pkg.sv
bus_decoder.sv
boot_rom.sv
scratch_ram.sv
clint_timer.sv
resp_mux.sv
debug_req_gate.sv
soc_top.sv
soc_asserts.sv
tb_soc_top.sv
